/* files.f */
source/sdp_rdma_pkg.sv
source/sdp_rdma_fifo.sv
source/sdp_rdma_ig.sv
source/sdp_rdma_eg.sv
source/sdp_rdma_dmaif.sv
source/sdp_nrdma.sv
verification/sdp_nrdma_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the SDP read DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module sdp_nrdma_tb -o sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
fi
exit 1

/* verification/sdp_nrdma_tb.sv */
// SDP normalization read DMA testbench
// random register sets per layer, a memory responder on both ports,
// a reference walk for requests and operand queues for the streams
`timescale 1ns/1ps
`default_nettype none

module sdp_nrdma_tb
  import sdp_rdma_pkg::*;
();

  localparam int unsigned num_layers = 14;
  localparam int unsigned done_limit = 5000;  // cycles per layer

  logic                      nvdla_core_clk;
  logic                      nvdla_core_rstn;
  logic                      op_en;
  logic [dma_aw-atom_aw-1:0] base_addr;
  logic [31-atom_aw:0]       line_stride;
  logic [31-atom_aw:0]       surface_stride;
  logic [12:0]               width;
  logic [12:0]               height;
  logic [12:0]               channel;
  data_use_e                 data_use;
  logic                      ram_type;
  logic                      perf_dma_en;
  logic                      mcif_req_valid;
  dma_rd_req_t               mcif_req_pd;
  logic                      mcif_rsp_ready;
  logic                      cvif_req_valid;
  dma_rd_req_t               cvif_req_pd;
  logic                      cvif_rsp_ready;
  logic                      mcif_cdt_pop;
  logic                      cvif_cdt_pop;
  logic                      alu_valid;
  logic                      alu_ready;
  dma_rd_rsp_t               alu_pd;
  logic                      mul_valid;
  logic                      mul_ready;
  dma_rd_rsp_t               mul_pd;
  logic                      done;
  logic [31:0]               stall_count;

  // memory side, index 1 is mcif and 0 is cvif
  logic [1:0]  req_rdy;
  logic [1:0]  rsp_vld;
  dma_rd_rsp_t rsp_dat [2];
  int unsigned owed [2];  // atoms still to return

  dma_rd_req_t exp_req [$];
  dma_rd_rsp_t exp_alu [$];
  dma_rd_rsp_t exp_mul [$];
  int unsigned req_gap;
  int unsigned rsp_gap;
  int unsigned out_gap;
  int unsigned hold_cnt;  // cycles of forced request back-pressure
  int unsigned pops;
  int unsigned rsp_cnt;
  int unsigned done_cnt;
  int unsigned err_val;
  int unsigned err_other;

  always #5 nvdla_core_clk = ~nvdla_core_clk;

  sdp_nrdma #(.lat_fifo_depth(16), .cq_depth(8)) dut (
    .*,
    .mcif_req_ready (req_rdy[1]),
    .mcif_rsp_valid (rsp_vld[1]),
    .mcif_rsp_pd    (rsp_dat[1]),
    .cvif_req_ready (req_rdy[0]),
    .cvif_rsp_valid (rsp_vld[0]),
    .cvif_rsp_pd    (rsp_dat[0])
  );

  //======================================================================
  // compare tasks
  //======================================================================
  task automatic check_req(input string name, input dma_rd_req_t got, input dma_rd_req_t exp);
    if (got !== exp) begin
      err_val++;
      $display("ERR %0t %s got addr=%h size=%0d exp addr=%h size=%0d",
               $time, name, got.addr, got.size, exp.addr, exp.size);
    end
  endtask

  task automatic check_atom(input string name, input dma_rd_rsp_t got, input dma_rd_rsp_t exp);
    if (got !== exp) begin
      err_val++;
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_val++;
      $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  //======================================================================
  // memory responder
  //======================================================================
  task automatic serve_port(input bit p, input logic rq_vld, input dma_rd_req_t rq_pd,
                            input logic rs_rdy, input logic pop);
    logic sel;
    logic sent;
    sel  = (ram_type == p);
    sent = rsp_vld[p] && rs_rdy;
    if (!sel && (rq_vld || pop)) begin
      err_other++;
      $display("[%0t] request or credit pop on unselected port %0d", $time, p);
    end
    if (rq_vld && req_rdy[p]) begin
      if (exp_req.size() == 0) begin
        err_other++;
        $display("[%0t] request beyond the end of the layer walk", $time);
      end else begin
        check_req("req_pd", rq_pd, exp_req.pop_front());
      end
      owed[p] += rq_pd.size + 1;
    end
    if (pop) pops++;
    if (sent) begin
      rsp_cnt++;
      if (data_use == use_alu || data_use == use_both) exp_alu.push_back(rsp_dat[p]);
      if (data_use == use_mul || data_use == use_both) exp_mul.push_back(rsp_dat[p]);
    end
    if ((!rsp_vld[p] || sent) && owed[p] != 0 && $urandom_range(99) >= rsp_gap) begin
      rsp_vld[p] <= 1'b1;
      rsp_dat[p] <= {$urandom, $urandom};
      owed[p]--;
    end else if (sent) begin
      rsp_vld[p] <= 1'b0;
    end
    req_rdy[p] <= (hold_cnt == 0) && ($urandom_range(99) >= req_gap);
  endtask

  always @(posedge nvdla_core_clk) begin
    serve_port(1'b1, mcif_req_valid, mcif_req_pd, mcif_rsp_ready, mcif_cdt_pop);
    serve_port(1'b0, cvif_req_valid, cvif_req_pd, cvif_rsp_ready, cvif_cdt_pop);
    if (hold_cnt != 0) hold_cnt--;
  end

  // operand streams, in order against the reference queues
  always @(posedge nvdla_core_clk) begin
    if (alu_valid && alu_ready) begin
      if (exp_alu.size() == 0) begin
        err_other++;
        $display("[%0t] alu operand with no response behind it", $time);
      end else begin
        check_atom("alu_pd", alu_pd, exp_alu.pop_front());
      end
    end
    if (mul_valid && mul_ready) begin
      if (exp_mul.size() == 0) begin
        err_other++;
        $display("[%0t] mul operand with no response behind it", $time);
      end else begin
        check_atom("mul_pd", mul_pd, exp_mul.pop_front());
      end
    end
    if (done) done_cnt++;
    alu_ready <= ($urandom_range(99) >= out_gap);
    mul_ready <= ($urandom_range(99) >= out_gap);
  end

  //======================================================================
  // one layer: pick registers, predict the walk, run until done
  //======================================================================
  task automatic run_layer(input int unsigned n, output bit timed_out);
    logic [60:0]  b;
    logic [28:0]  ls;
    logic [28:0]  ss;
    logic [12:0]  w;
    logic [12:0]  h;
    logic [12:0]  c;
    logic         rt;
    logic         pe;
    data_use_e    du;
    logic [63:0]  a;
    dma_rd_req_t  r;
    int           surf;
    int unsigned  cycles;
    @(negedge nvdla_core_clk);
    b  = 61'($urandom_range(32'hf_ffff));
    ls = 29'($urandom_range(2048));
    ss = 29'($urandom_range(16384));
    w  = 13'($urandom_range(6));
    h  = 13'($urandom_range(4));
    c  = 13'($urandom_range(20));
    du = data_use_e'(2'(n % 3));
    rt = 1'($urandom_range(1));
    pe = 1'($urandom_range(1));
    if (n < 2) begin  // stall layers, few enough requests to fit the cq
      rt = 1'b1;
      pe = 1'b1;
      c  = 13'($urandom_range(7));
      h  = 13'($urandom_range(5));
    end
    exp_req.delete();
    exp_alu.delete();
    exp_mul.delete();
    surf = (int'(c) + 8) / 8;  // ceil((channel+1)/8)
    for (int s = 0; s < surf; s++) begin
      for (int l = 0; l <= int'(h); l++) begin
        a = 64'(b) + 64'(l) * 64'(ls) + 64'(s) * 64'(ss);
        r.addr = a << atom_aw;
        r.size = req_size_w'(w);
        exp_req.push_back(r);
      end
    end
    req_gap  = (n == 0) ? 0 : $urandom_range(60);
    rsp_gap  = $urandom_range(60);
    out_gap  = $urandom_range(60);
    hold_cnt = (n == 1) ? 20 : 0;
    pops     = 0;
    rsp_cnt  = 0;

    @(posedge nvdla_core_clk);
    base_addr      <= b;
    line_stride    <= ls;
    surface_stride <= ss;
    width          <= w;
    height         <= h;
    channel        <= c;
    data_use       <= du;
    ram_type       <= rt;
    perf_dma_en    <= pe;
    op_en          <= 1'b1;
    @(posedge nvdla_core_clk);
    op_en <= 1'b0;

    cycles = 0;
    @(negedge nvdla_core_clk);
    while (!done && cycles < done_limit) begin
      @(negedge nvdla_core_clk);
      cycles++;
    end
    timed_out = !done;
    if (timed_out) begin
      err_other++;
      $display("timeout: layer %0d gave no done within %0d cycles", n, done_limit);
    end else begin
      check_count("requests_left", exp_req.size(), 0);
      check_count("alu_atoms_left", exp_alu.size(), 0);
      check_count("mul_atoms_left", exp_mul.size(), 0);
      check_count("owed_atoms", owed[rt], 0);
      check_count("cdt_pop_count", pops, rsp_cnt);
      if (n == 0) check_count("stall_count", stall_count, 0);
      if (n == 1 && stall_count == 0) begin
        err_other++;
        $display("stall_count stayed zero while mcif request ready was held low");
      end
      repeat (4) @(posedge nvdla_core_clk);
      @(negedge nvdla_core_clk);
      check_count("done_pulses", done_cnt, n + 1);
    end
  endtask

  initial begin
    bit          timed_out;
    int unsigned n;
    void'($urandom(32'h2516_acee));
    nvdla_core_clk  = 1'b0;
    nvdla_core_rstn = 1'b0;
    op_en           = 1'b0;
    base_addr       = '0;
    line_stride     = '0;
    surface_stride  = '0;
    width           = '0;
    height          = '0;
    channel         = '0;
    data_use        = use_mul;
    ram_type        = 1'b1;
    perf_dma_en     = 1'b0;
    alu_ready       = 1'b0;
    mul_ready       = 1'b0;
    req_rdy         = '0;
    rsp_vld         = '0;
    rsp_dat[0]      = '0;
    rsp_dat[1]      = '0;
    owed[0]         = 0;
    owed[1]         = 0;
    req_gap         = 0;
    rsp_gap         = 0;
    out_gap         = 0;
    hold_cnt        = 0;
    pops            = 0;
    rsp_cnt         = 0;
    done_cnt        = 0;
    err_val         = 0;
    err_other       = 0;
    timed_out       = 1'b0;

    repeat (5) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;

    for (n = 0; n < num_layers && !timed_out; n++) begin
      run_layer(n, timed_out);
    end

    $display("layers %0d, value errors %0d, other errors %0d", n, err_val, err_other);
    if (err_val == 0 && err_other == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/sdp_nrdma.sv */
// SDP normalization-data read DMA
// layer latch plus ingress, context queue, memory router,
// latency FIFO and egress
`timescale 1ns/1ps
`default_nettype none

module sdp_nrdma
  import sdp_rdma_pkg::*;
#(
  parameter int lat_fifo_depth = 16,
  parameter int cq_depth       = 8
) (
  input  wire logic                      nvdla_core_clk,
  input  wire logic                      nvdla_core_rstn,
  input  wire logic                      op_en,
  input  wire logic [dma_aw-atom_aw-1:0] base_addr,
  input  wire logic [31-atom_aw:0]       line_stride,
  input  wire logic [31-atom_aw:0]       surface_stride,
  input  wire logic [12:0]               width,
  input  wire logic [12:0]               height,
  input  wire logic [12:0]               channel,
  input  wire data_use_e                 data_use,
  input  wire logic                      ram_type,
  input  wire logic                      perf_dma_en,
  output logic                           mcif_req_valid,
  input  wire logic                      mcif_req_ready,
  output dma_rd_req_t                    mcif_req_pd,
  input  wire logic                      mcif_rsp_valid,
  output logic                           mcif_rsp_ready,
  input  wire dma_rd_rsp_t               mcif_rsp_pd,
  output logic                           cvif_req_valid,
  input  wire logic                      cvif_req_ready,
  output dma_rd_req_t                    cvif_req_pd,
  input  wire logic                      cvif_rsp_valid,
  output logic                           cvif_rsp_ready,
  input  wire dma_rd_rsp_t               cvif_rsp_pd,
  output logic                           mcif_cdt_pop,
  output logic                           cvif_cdt_pop,
  output logic                           alu_valid,
  input  wire logic                      alu_ready,
  output dma_rd_rsp_t                    alu_pd,
  output logic                           mul_valid,
  input  wire logic                      mul_ready,
  output dma_rd_rsp_t                    mul_pd,
  output logic                           done,
  output logic [31:0]                    stall_count
);

  logic        layer_process;
  logic        op_load;
  logic        eg_done;
  logic        req_valid, req_ready;
  dma_rd_req_t req_pd;
  logic        rsp_valid, rsp_ready;
  dma_rd_rsp_t rsp_pd;
  logic        ig2cq_valid, ig2cq_ready;
  cq_entry_t   ig2cq_pd;
  logic        cq2eg_valid, cq2eg_ready;
  cq_entry_t   cq2eg_pd;
  logic        lat_valid, lat_ready;
  dma_rd_rsp_t lat_pd;
  logic        cdt_pop;

  //======================================================================
  // layer switch
  //======================================================================
  assign op_load = op_en && !layer_process;  // one cycle per layer
  assign done    = eg_done;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      layer_process <= 1'b0;
    end else if (op_load) begin
      layer_process <= 1'b1;
    end else if (eg_done) begin
      layer_process <= 1'b0;
    end
  end

  sdp_rdma_ig u_ig (
    .nvdla_core_clk, .nvdla_core_rstn, .op_load,
    .base_addr, .line_stride, .surface_stride, .width, .height, .channel, .perf_dma_en,
    .req_valid, .req_ready, .req_pd,
    .cq_valid (ig2cq_valid), .cq_ready (ig2cq_ready), .cq_pd (ig2cq_pd),
    .stall_count
  );

  sdp_rdma_fifo #(.depth(cq_depth), .payload_t(cq_entry_t)) u_cq (
    .nvdla_core_clk, .nvdla_core_rstn,
    .wr_valid (ig2cq_valid), .wr_ready (ig2cq_ready), .wr_pd (ig2cq_pd),
    .rd_valid (cq2eg_valid), .rd_ready (cq2eg_ready), .rd_pd (cq2eg_pd)
  );

  sdp_rdma_dmaif u_dmaif (
    .nvdla_core_clk, .nvdla_core_rstn, .ram_type,
    .req_valid, .req_ready, .req_pd, .rsp_valid, .rsp_ready, .rsp_pd,
    .mcif_req_valid, .mcif_req_ready, .mcif_req_pd,
    .mcif_rsp_valid, .mcif_rsp_ready, .mcif_rsp_pd,
    .cvif_req_valid, .cvif_req_ready, .cvif_req_pd,
    .cvif_rsp_valid, .cvif_rsp_ready, .cvif_rsp_pd,
    .cdt_pop, .mcif_cdt_pop, .cvif_cdt_pop
  );

  sdp_rdma_fifo #(.depth(lat_fifo_depth), .payload_t(dma_rd_rsp_t)) u_lat_fifo (
    .nvdla_core_clk, .nvdla_core_rstn,
    .wr_valid (rsp_valid), .wr_ready (rsp_ready), .wr_pd (rsp_pd),
    .rd_valid (lat_valid), .rd_ready (lat_ready), .rd_pd (lat_pd)
  );

  sdp_rdma_eg u_eg (
    .nvdla_core_clk, .nvdla_core_rstn, .op_load, .height, .channel, .data_use,
    .cq_valid (cq2eg_valid), .cq_ready (cq2eg_ready), .cq_pd (cq2eg_pd),
    .lat_valid, .lat_ready, .lat_pd, .cdt_pop,
    .alu_valid, .alu_ready, .alu_pd, .mul_valid, .mul_ready, .mul_pd,
    .done (eg_done)
  );

endmodule

`default_nettype wire

/* source/sdp_rdma_dmaif.sv */
// SDP read DMA memory interface
// steers requests, responses and credit pops to mcif or cvif by ram_type
// ram_type 1 selects mcif, 0 selects cvif
`timescale 1ns/1ps
`default_nettype none

module sdp_rdma_dmaif
  import sdp_rdma_pkg::*;
(
  input  wire logic        nvdla_core_clk,
  input  wire logic        nvdla_core_rstn,
  input  wire logic        ram_type,
  input  wire logic        req_valid,
  output logic             req_ready,
  input  wire dma_rd_req_t req_pd,
  output logic             rsp_valid,
  input  wire logic        rsp_ready,
  output dma_rd_rsp_t      rsp_pd,
  output logic             mcif_req_valid,
  input  wire logic        mcif_req_ready,
  output dma_rd_req_t      mcif_req_pd,
  input  wire logic        mcif_rsp_valid,
  output logic             mcif_rsp_ready,
  input  wire dma_rd_rsp_t mcif_rsp_pd,
  output logic             cvif_req_valid,
  input  wire logic        cvif_req_ready,
  output dma_rd_req_t      cvif_req_pd,
  input  wire logic        cvif_rsp_valid,
  output logic             cvif_rsp_ready,
  input  wire dma_rd_rsp_t cvif_rsp_pd,
  input  wire logic        cdt_pop,
  output logic             mcif_cdt_pop,
  output logic             cvif_cdt_pop
);

  logic in_valid;
  logic in_ready;

  // request side
  assign mcif_req_valid = req_valid && ram_type;
  assign cvif_req_valid = req_valid && !ram_type;
  assign mcif_req_pd    = req_pd;
  assign cvif_req_pd    = req_pd;
  assign req_ready      = ram_type ? mcif_req_ready : cvif_req_ready;

  // response side, one register stage ahead of the latency FIFO
  assign in_valid       = ram_type ? mcif_rsp_valid : cvif_rsp_valid;
  assign in_ready       = !rsp_valid || rsp_ready;
  assign mcif_rsp_ready = ram_type && in_ready;
  assign cvif_rsp_ready = !ram_type && in_ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      rsp_valid <= 1'b0;
    end else if (in_ready) begin
      rsp_valid <= in_valid;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (in_valid && in_ready) begin
      rsp_pd <= ram_type ? mcif_rsp_pd : cvif_rsp_pd;
    end
  end

  assign mcif_cdt_pop = cdt_pop && ram_type;  // credit back to the serving port
  assign cvif_cdt_pop = cdt_pop && !ram_type;

endmodule

`default_nettype wire

/* source/sdp_rdma_eg.sv */
// SDP read DMA egress
// pairs latency FIFO atoms with cq entries and forwards them in order
// to the ALU and/or multiplier operand streams, then flags layer done
`timescale 1ns/1ps
`default_nettype none

module sdp_rdma_eg
  import sdp_rdma_pkg::*;
(
  input  wire logic        nvdla_core_clk,
  input  wire logic        nvdla_core_rstn,
  input  wire logic        op_load,
  input  wire logic [12:0] height,
  input  wire logic [12:0] channel,
  input  wire data_use_e   data_use,
  input  wire logic        cq_valid,
  output logic             cq_ready,
  input  wire cq_entry_t   cq_pd,
  input  wire logic        lat_valid,
  output logic             lat_ready,
  input  wire dma_rd_rsp_t lat_pd,
  output logic             cdt_pop,
  output logic             alu_valid,
  input  wire logic        alu_ready,
  output dma_rd_rsp_t      alu_pd,
  output logic             mul_valid,
  input  wire logic        mul_ready,
  output dma_rd_rsp_t      mul_pd,
  output logic             done
);

  logic        atom_vld;   // holding a request
  cq_entry_t   atom_cnt;   // atoms left minus one
  logic        atom_last;
  logic        need_alu;
  logic        need_mul;
  logic        lat_pop;
  logic        layer_act;
  logic [10:0] surf_num;
  logic [13:0] line_num;
  logic [24:0] req_total;
  logic [24:0] req_cnt;

  assign need_alu  = (data_use != use_mul);
  assign need_mul  = (data_use != use_alu);
  assign atom_last = (atom_cnt == '0);

  // pop only when every selected output register can take the atom
  assign lat_ready = atom_vld && (!need_alu || !alu_valid || alu_ready)
                              && (!need_mul || !mul_valid || mul_ready);
  assign lat_pop   = lat_valid && lat_ready;
  assign cdt_pop   = lat_pop;  // one credit per atom
  assign cq_ready  = !atom_vld || (lat_pop && atom_last);

  assign surf_num = 11'(channel[12:3]) + 11'd1;
  assign line_num = 14'(height) + 14'd1;

  //======================================================================
  // request countdown
  //======================================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      atom_vld <= 1'b0;
      atom_cnt <= '0;
    end else if (cq_valid && cq_ready) begin
      atom_vld <= 1'b1;
      atom_cnt <= cq_pd;
    end else if (lat_pop) begin
      if (atom_last) begin
        atom_vld <= 1'b0;
      end else begin
        atom_cnt <= atom_cnt - 1'b1;
      end
    end
  end

  //======================================================================
  // operand stream registers
  //======================================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      alu_valid <= 1'b0;
      mul_valid <= 1'b0;
    end else begin
      if (lat_pop && need_alu) alu_valid <= 1'b1;
      else if (alu_ready)      alu_valid <= 1'b0;
      if (lat_pop && need_mul) mul_valid <= 1'b1;
      else if (mul_ready)      mul_valid <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (lat_pop && need_alu) alu_pd <= lat_pd;
    if (lat_pop && need_mul) mul_pd <= lat_pd;
  end

  //======================================================================
  // layer completion
  //======================================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      layer_act <= 1'b0;
      req_cnt   <= '0;
      req_total <= '0;
    end else if (op_load) begin
      layer_act <= 1'b1;
      req_cnt   <= '0;
      req_total <= 25'(surf_num) * 25'(line_num);  // surfaces x lines
    end else begin
      if (lat_pop && atom_last) req_cnt <= req_cnt + 1'b1;
      if (done)                 layer_act <= 1'b0;
    end
  end

  // high the cycle after the last operand leaves
  assign done = layer_act && (req_cnt == req_total) && !alu_valid && !mul_valid;

  a_alu_stable: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    alu_valid && !alu_ready |=> alu_valid && $stable(alu_pd))
    else $error("alu operand dropped or changed before transfer");

  a_mul_stable: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    mul_valid && !mul_ready |=> mul_valid && $stable(mul_pd))
    else $error("mul operand dropped or changed before transfer");

endmodule

`default_nettype wire

/* source/sdp_rdma_ig.sv */
// SDP read DMA ingress
// walks lines inside surfaces, one read request per line,
// pushes the atom count of each request to the context queue
`timescale 1ns/1ps
`default_nettype none

module sdp_rdma_ig
  import sdp_rdma_pkg::*;
(
  input  wire logic                    nvdla_core_clk,
  input  wire logic                    nvdla_core_rstn,
  input  wire logic                    op_load,
  input  wire logic [dma_aw-atom_aw-1:0] base_addr,
  input  wire logic [31-atom_aw:0]     line_stride,
  input  wire logic [31-atom_aw:0]     surface_stride,
  input  wire logic [12:0]             width,
  input  wire logic [12:0]             height,
  input  wire logic [12:0]             channel,
  input  wire logic                    perf_dma_en,
  output logic                         req_valid,
  input  wire logic                    req_ready,
  output dma_rd_req_t                  req_pd,
  output logic                         cq_valid,
  input  wire logic                    cq_ready,
  output cq_entry_t                    cq_pd,
  output logic [31:0]                  stall_count
);

  localparam int baw = dma_aw - atom_aw;

  logic            running;
  logic [9:0]      surf_cnt;
  logic [12:0]     line_cnt;
  logic [baw-1:0]  surf_addr;  // first line of current surface
  logic [baw-1:0]  line_addr;  // current line, in atoms
  logic            accept;
  logic            line_last;
  logic            surf_last;

  // request only offered when its cq entry fits
  assign req_valid = running && cq_ready;
  assign cq_valid  = running && req_ready;
  assign accept    = req_valid && req_ready;

  assign req_pd.addr = {line_addr, {atom_aw{1'b0}}};
  assign req_pd.size = req_size_w'(width);
  assign cq_pd       = cq_entry_t'(width);

  assign line_last = (line_cnt == height);
  assign surf_last = (surf_cnt == channel[12:3]);  // 8 channels per surface

  //======================================================================
  // surface / line walk
  //======================================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      running   <= 1'b0;
      surf_cnt  <= '0;
      line_cnt  <= '0;
      surf_addr <= '0;
      line_addr <= '0;
    end else if (op_load) begin
      running   <= 1'b1;
      surf_cnt  <= '0;
      line_cnt  <= '0;
      surf_addr <= base_addr;
      line_addr <= base_addr;
    end else if (accept) begin
      if (line_last) begin
        line_cnt  <= '0;
        surf_cnt  <= surf_cnt + 1'b1;
        surf_addr <= surf_addr + baw'(surface_stride);
        line_addr <= surf_addr + baw'(surface_stride);  // next surface base
        if (surf_last) begin
          running <= 1'b0;  // layer fully issued
        end
      end else begin
        line_cnt  <= line_cnt + 1'b1;
        line_addr <= line_addr + baw'(line_stride);
      end
    end
  end

  // cycles with work pending but no request taken
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_count <= '0;
    end else if (op_load) begin
      stall_count <= '0;
    end else if (perf_dma_en && running && !accept) begin
      stall_count <= stall_count + 1'b1;
    end
  end

  a_req_stable: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    req_valid && !req_ready |=> req_valid && $stable(req_pd))
    else $error("read request dropped or changed before transfer");

endmodule

`default_nettype wire

/* source/sdp_rdma_fifo.sv */
// SDP read DMA FIFO
// register-array FIFO with valid/ready on both sides
// serves the context queue and the latency FIFO through payload_t
`timescale 1ns/1ps
`default_nettype none

module sdp_rdma_fifo #(
  parameter int  depth     = 8,
  parameter type payload_t = logic [7:0]
) (
  input  wire logic     nvdla_core_clk,
  input  wire logic     nvdla_core_rstn,
  input  wire logic     wr_valid,
  output logic          wr_ready,
  input  wire payload_t wr_pd,
  output logic          rd_valid,
  input  wire logic     rd_ready,
  output payload_t      rd_pd
);

  localparam int aw = (depth > 1) ? $clog2(depth) : 1;
  localparam int cw = $clog2(depth + 1);

  payload_t        mem [depth];
  logic [aw-1:0]   wr_ptr;
  logic [aw-1:0]   rd_ptr;
  logic [cw-1:0]   count;
  logic            push;
  logic            pop;

  assign wr_ready = (count != cw'(depth));
  assign rd_valid = (count != '0);
  assign rd_pd    = mem[rd_ptr];
  assign push     = wr_valid && wr_ready;
  assign pop      = rd_valid && rd_ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push != pop) begin
        count <= push ? count + 1'b1 : count - 1'b1;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_pd;  // payload only, no reset
    end
  end

  // pointers meet only when empty or full
  a_no_overflow: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (wr_ptr == rd_ptr) == (count == '0 || count == cw'(depth)))
    else $error("fifo pointers lapped");

endmodule

`default_nettype wire

/* source/sdp_rdma_pkg.sv */
// SDP normalization read DMA shared definitions
// bus widths, request layout, context queue entry and data-use encoding
`default_nettype none

package sdp_rdma_pkg;

  //======================================================================
  // widths
  //======================================================================
  localparam int dma_aw     = 64;  // byte address
  localparam int dma_dw     = 64;  // one atom per response beat
  localparam int atom_aw    = 3;   // 8-byte atoms
  localparam int req_size_w = 15;  // atom count minus one

  //======================================================================
  // payloads
  //======================================================================
  typedef struct packed {
    logic [dma_aw-1:0]     addr;  // byte address, atom aligned
    logic [req_size_w-1:0] size;  // atoms minus one
  } dma_rd_req_t;

  typedef logic [dma_dw-1:0] dma_rd_rsp_t;

  // atoms of one request, minus one
  typedef logic [req_size_w-1:0] cq_entry_t;

  // which operand streams take the data
  typedef enum logic [1:0] {
    use_mul  = 2'd0,
    use_alu  = 2'd1,
    use_both = 2'd2
  } data_use_e;

endpackage

`default_nettype wire
